// ==== hdl/sd_share_pkg.sv ====
// disk count, disk indices, default card levels, request and spi line types, arbiter states
package sd_share_pkg;

   //**************************************************
   // disk set
   //**************************************************

   // five controllers hang off the one card
   localparam int NUM_DISKS = 5;          // rk, dw, dm, dx, my

   // bit positions in every per-disk vector
   // a lower index wins the card first
   localparam int DISK_RK   = 0;          // rk11 cartridge disk
   localparam int DISK_DW   = 1;          // dw winchester
   localparam int DISK_DM   = 2;          // rk611 disk
   localparam int DISK_DX   = 3;          // rx01 floppy
   localparam int DISK_MY   = 4;          // my floppy, lowest priority

   //**************************************************
   // card pin levels with no holder
   //**************************************************

   localparam logic SD_DEF_CS   = 1'b1;   // card deselected
   localparam logic SD_DEF_MOSI = 1'b1;   // data line idles high
   localparam logic SD_DEF_SCLK = 1'b0;   // clock parked low

   //**************************************************
   // types
   //**************************************************

   // one bit per disk
   // used for requests, grants and leds alike
   typedef logic [NUM_DISKS-1:0] disk_vec_t;

   // the three card lines one source drives
   // miso is a broadcast wire and stays outside
   typedef struct packed {
      logic cs;                           // chip select, low active
      logic mosi;                         // host to card data
      logic sclk;                         // spi clock
   } sd_spi_t;

   // one line set per controller
   typedef sd_spi_t [NUM_DISKS-1:0] disk_spi_t;

   // card arbiter states
   typedef enum logic {
      ARB_IDLE = 1'b0,                    // no holder, looking for a requester
      ARB_BUSY = 1'b1                     // one disk owns the card
   } arb_state_t;

endpackage

// ==== hdl/sd_req_filter.sv ====
// two-stage request filter for the card arbiter and active-low request led drive
`timescale 1ns/1ps

module sd_req_filter
   import sd_share_pkg::*;
(
   input  logic      sdclock,          // card clock domain
   input  logic      reset_i,          // sync reset, high active
   input  disk_vec_t disk_req_i,       // raw request levels from the controllers
   output disk_vec_t req_filt_o,       // settled requests to the arbiter
   output disk_vec_t disk_led_n_o      // request leds, low lit
);

   //**************************************************
   // filter stages
   //**************************************************

   // controllers may run off other clocks
   // two flops let each level settle before the arbiter looks at it
   disk_vec_t req_s0_q;                // first sample of raw requests
   disk_vec_t req_s1_q;                // second sample, feeds the arbiter

   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         req_s0_q <= '0;               // nobody asking
         req_s1_q <= '0;
      end else begin
         req_s0_q <= disk_req_i;       // edge 1 after a change
         req_s1_q <= req_s0_q;         // edge 2 after a change
      end
   end

   // arbiter only ever sees the second stage
   assign req_filt_o = req_s1_q;

   //**************************************************
   // request leds
   //**************************************************

   // leds follow the raw request with no delay
   // so a stuck controller shows up even if the filter is held in reset
   assign disk_led_n_o = ~disk_req_i;  // lit while requesting

endmodule

// ==== hdl/sd_arbiter.sv ====
// sd card grant state machine with fixed priority and hold until release, plus card pin mux
`timescale 1ns/1ps

module sd_arbiter
   import sd_share_pkg::*;
(
   input  logic      sdclock,          // card clock domain
   input  logic      reset_i,          // sync reset, high active
   input  disk_vec_t req_filt_i,       // filtered request levels
   input  disk_spi_t disk_spi_i,       // card lines from each controller
   output disk_vec_t disk_gnt_o,       // one-hot grant, zero when idle
   output sd_spi_t   sdcard_o          // lines to the card pins
);

   arb_state_t state_q;                // current arbiter state
   arb_state_t state_d;                // next arbiter state
   disk_vec_t  gnt_q;                  // grant register
   disk_vec_t  gnt_d;                  // next grant
   disk_vec_t  pick;                   // winner among current requesters
   logic       any_req;                // at least one disk waiting
   logic       holder_req;             // holder still wants the card

   //**************************************************
   // request decode
   //**************************************************

   // fixed priority, lowest index first
   // rk beats everyone and my only wins when alone
   always_comb begin
      pick = '0;
      if (req_filt_i[DISK_RK]) begin
         pick[DISK_RK] = 1'b1;         // rk11
      end else if (req_filt_i[DISK_DW]) begin
         pick[DISK_DW] = 1'b1;         // dw
      end else if (req_filt_i[DISK_DM]) begin
         pick[DISK_DM] = 1'b1;         // rk611
      end else if (req_filt_i[DISK_DX]) begin
         pick[DISK_DX] = 1'b1;         // rx01
      end else if (req_filt_i[DISK_MY]) begin
         pick[DISK_MY] = 1'b1;         // my
      end
   end

   assign any_req    = |req_filt_i;              // someone is asking
   assign holder_req = |(req_filt_i & gnt_q);    // only the holder's bit counts

   //**************************************************
   // state machine
   //**************************************************

   always_comb begin
      state_d = state_q;
      case (state_q)
         ARB_IDLE: begin
            if (any_req) begin
               state_d = ARB_BUSY;     // card handed out this edge
            end
         end
         ARB_BUSY: begin
            if (!holder_req) begin
               state_d = ARB_IDLE;     // holder let go
            end
         end
         default: begin
            state_d = ARB_IDLE;        // unreachable encodings fall back to idle
         end
      endcase
   end

   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         state_q <= ARB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //**************************************************
   // grant register
   //**************************************************

   // new requests are ignored while the card is held
   // a release always passes through one all-zero cycle in idle
   always_comb begin
      gnt_d = gnt_q;
      case (state_q)
         ARB_IDLE: begin
            gnt_d = pick;              // zero when nobody asks
         end
         ARB_BUSY: begin
            if (!holder_req) begin
               gnt_d = '0;             // drop grant with the request
            end
         end
         default: begin
            gnt_d = '0;
         end
      endcase
   end

   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         gnt_q <= '0;                  // card free
      end else begin
         gnt_q <= gnt_d;
      end
   end

   assign disk_gnt_o = gnt_q;

   //**************************************************
   // pin mux
   //**************************************************

   // grant is one-hot, so at most one source matches
   // with no holder the card sees the idle levels
   always_comb begin
      sdcard_o.cs   = SD_DEF_CS;       // deselected
      sdcard_o.mosi = SD_DEF_MOSI;     // idle high
      sdcard_o.sclk = SD_DEF_SCLK;     // clock low
      for (int i = 0; i < NUM_DISKS; i++) begin
         if (gnt_q[i]) begin
            sdcard_o = disk_spi_i[i];  // holder drives the pins
         end
      end
   end

endmodule

// ==== hdl/sd_backplane.sv ====
// top level of the shared sd card logic with the request filter feeding the card arbiter
`timescale 1ns/1ps

module sd_backplane
   import sd_share_pkg::*;
(
   input  logic      sdclock,          // card clock
   input  logic      reset_i,          // sync reset, high active

   // controller side
   input  disk_vec_t disk_req_i,       // request level per disk
   input  disk_spi_t disk_spi_i,       // cs, mosi, sclk per disk
   output disk_vec_t disk_gnt_o,       // card grant per disk

   // card side
   output sd_spi_t   sdcard_o,         // to the card pins

   // front panel
   output disk_vec_t disk_led_n_o      // request leds, low lit
);

   //**************************************************
   // internal wiring
   //**************************************************

   disk_vec_t req_filt;                // settled requests, two edges behind the inputs

   //**************************************************
   // request filter
   //**************************************************

   sd_req_filter req_filter (
      .sdclock      (sdclock),
      .reset_i      (reset_i),
      .disk_req_i   (disk_req_i),      // raw from controllers
      .req_filt_o   (req_filt),        // into the arbiter
      .disk_led_n_o (disk_led_n_o)     // straight to the panel
   );

   //**************************************************
   // card arbiter and pin mux
   //**************************************************

   // grant lands one edge after the filtered request
   // three edges after the raw request in all
   sd_arbiter arbiter (
      .sdclock    (sdclock),
      .reset_i    (reset_i),
      .req_filt_i (req_filt),          // filtered requests
      .disk_spi_i (disk_spi_i),        // candidate line sets
      .disk_gnt_o (disk_gnt_o),        // back to controllers
      .sdcard_o   (sdcard_o)           // holder lines or defaults
   );

endmodule

// ==== dv/sd_arbiter_asserts.sv ====
// concurrent grant checks for the card arbiter and their bind into sd_arbiter
`timescale 1ns/1ps

module sd_arbiter_asserts
   import sd_share_pkg::*;
(
   input logic      sdclock,           // card clock
   input logic      reset_i,           // sync reset, high active
   input disk_vec_t req_filt_i,        // filtered requests seen by the arbiter
   input disk_vec_t disk_gnt_o         // grant register
);

   //**************************************************
   // grant shape
   //**************************************************

   // never two holders at once
   grant_onehot: assert property (
      @(posedge sdclock) disable iff (reset_i)
      $onehot0(disk_gnt_o)
   ) else $error("card grant has more than one bit set: %b", disk_gnt_o);

   //**************************************************
   // grant causes
   //**************************************************

   // a new grant bit needs its filtered request on the edge before
   grant_needs_req: assert property (
      @(posedge sdclock) disable iff (reset_i)
      (disk_gnt_o & ~$past(disk_gnt_o) & ~$past(req_filt_i)) == '0
   ) else $error("grant rose without a filtered request: %b", disk_gnt_o);

   // handoff always goes through an all-zero cycle
   grant_no_jump: assert property (
      @(posedge sdclock) disable iff (reset_i)
      ($past(disk_gnt_o) != '0 && disk_gnt_o != '0) |-> (disk_gnt_o == $past(disk_gnt_o))
   ) else $error("grant moved between disks without an idle cycle");

endmodule

bind sd_arbiter sd_arbiter_asserts arb_asserts (
   .sdclock    (sdclock),
   .reset_i    (reset_i),
   .req_filt_i (req_filt_i),
   .disk_gnt_o (disk_gnt_o)
);

// ==== dv/sd_backplane_tb.sv ====
// testbench for the shared sd card backplane with clock, reset, stimulus table, checks and report
`timescale 1ns/1ps

module sd_backplane_tb
   import sd_share_pkg::*;
();

   // one table row with expected values for its last cycle
   typedef struct packed {
      disk_vec_t req;                  // raw request levels driven
      int        cycles;               // rising edges to hold them
      disk_vec_t gnt;                  // expected grant
      disk_vec_t led;                  // expected leds, low lit
      logic      idle;                 // card lines expected at defaults
   } row_t;

   logic      sdclock;
   logic      reset_i;
   disk_vec_t disk_req_i;
   disk_spi_t disk_spi_i;
   disk_vec_t disk_gnt_o;
   sd_spi_t   sdcard_o;
   disk_vec_t disk_led_n_o;

   row_t        rows[$];               // stimulus table
   disk_spi_t   spi_pat;               // current per-disk line patterns
   logic [31:0] lcg_state;             // random state
   int          err_count;             // failed checks
   int          check_count;           // checks done
   logic        timed_out;             // a wait ran out

   sd_backplane sd_backplane_i (
      .sdclock      (sdclock),
      .reset_i      (reset_i),
      .disk_req_i   (disk_req_i),
      .disk_spi_i   (disk_spi_i),
      .disk_gnt_o   (disk_gnt_o),
      .sdcard_o     (sdcard_o),
      .disk_led_n_o (disk_led_n_o)
   );

   always #20 sdclock = ~sdclock;      // 40 ns period

   //**************************************************
   // helpers
   //**************************************************

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
   endfunction

   // card lines a correct mux shows for a given grant
   function automatic sd_spi_t expected_card(input disk_vec_t gnt, input disk_spi_t pat,
                                             input logic idle);
      sd_spi_t c;
      c.cs   = SD_DEF_CS;
      c.mosi = SD_DEF_MOSI;
      c.sclk = SD_DEF_SCLK;
      if (!idle) begin
         for (int d = 0; d < NUM_DISKS; d++) begin
            if (gnt[d]) begin
               c = pat[d];             // holder lines
            end
         end
      end
      return c;
   endfunction

   // distinct line sets per disk, none equal to the idle levels
   task automatic fill_patterns();
      logic [7:0] used;
      sd_spi_t    cand;
      int         tries;
      used = '0;
      used[{SD_DEF_CS, SD_DEF_MOSI, SD_DEF_SCLK}] = 1'b1;   // idle levels excluded
      for (int d = 0; d < NUM_DISKS; d++) begin
         tries = 0;
         lcg_state = lcg_next(lcg_state);
         cand = sd_spi_t'(lcg_state[30:28]);   // upper bits have the better period
         while (used[cand] && tries < 64) begin
            lcg_state = lcg_next(lcg_state);
            cand = sd_spi_t'(lcg_state[30:28]);
            tries++;
         end
         used[cand] = 1'b1;
         spi_pat[d] = cand;
      end
   endtask

   task automatic add_row(input disk_vec_t req, input int cycles, input disk_vec_t gnt,
                          input disk_vec_t led, input logic idle);
      row_t r;
      r.req    = req;
      r.cycles = cycles;
      r.gnt    = gnt;
      r.led    = led;
      r.idle   = idle;
      rows.push_back(r);
   endtask

   task automatic check_outputs(input disk_vec_t gnt, input disk_vec_t led, input sd_spi_t card);
      check_count++;
      if (disk_gnt_o !== gnt) begin
         $display("Fail at %0t: disk_gnt_o expected %b got %b", $time, gnt, disk_gnt_o);
         err_count++;
      end
      if (disk_led_n_o !== led) begin
         $display("Fail at %0t: disk_led_n_o expected %b got %b", $time, led, disk_led_n_o);
         err_count++;
      end
      if (sdcard_o !== card) begin
         $display("Fail at %0t: sdcard_o expected %b got %b", $time, card, sdcard_o);
         err_count++;
      end
   endtask

   // wait for the card to come free
   task automatic wait_card_free(input int max_cycles);
      int n;
      n = 0;
      while (disk_gnt_o != '0 && n < max_cycles) begin
         @(posedge sdclock);
         #1;                           // settled after the edge
         n++;
      end
      if (disk_gnt_o != '0) begin
         $display("Timeout: the card grant did not clear within %0d cycles", max_cycles);
         timed_out = 1'b1;
      end
   endtask

   //**************************************************
   // stimulus table
   //**************************************************

   // bits are my, dx, dm, dw, rk
   task automatic build_table();
      add_row(5'b00000, 4, 5'b00000, 5'b11111, 1'b1);   // idle after reset
      add_row(5'b01000, 2, 5'b00000, 5'b10111, 1'b1);   // dx, still filtering
      add_row(5'b01000, 1, 5'b01000, 5'b10111, 1'b0);   // third edge grants
      add_row(5'b01000, 4, 5'b01000, 5'b10111, 1'b0);   // dx holds
      add_row(5'b00000, 2, 5'b01000, 5'b11111, 1'b0);   // release in flight
      add_row(5'b00000, 1, 5'b00000, 5'b11111, 1'b1);   // third edge drops it
      add_row(5'b00000, 4, 5'b00000, 5'b11111, 1'b1);
      add_row(5'b11010, 4, 5'b00010, 5'b00101, 1'b0);   // dw beats dx and my
      add_row(5'b00000, 4, 5'b00000, 5'b11111, 1'b1);
      add_row(5'b10000, 4, 5'b10000, 5'b01111, 1'b0);   // my takes the card
      add_row(5'b10001, 6, 5'b10000, 5'b01110, 1'b0);   // rk waits without preemption
      add_row(5'b00001, 2, 5'b10000, 5'b11110, 1'b0);   // my release in flight
      add_row(5'b00001, 1, 5'b00000, 5'b11110, 1'b1);   // the all-zero cycle
      add_row(5'b00001, 1, 5'b00001, 5'b11110, 1'b0);   // rk gets it next edge
      add_row(5'b00001, 4, 5'b00001, 5'b11110, 1'b0);
      add_row(5'b00000, 4, 5'b00000, 5'b11111, 1'b1);
      add_row(5'b10110, 4, 5'b00010, 5'b01001, 1'b0);   // dw, dm, my pending
      add_row(5'b10100, 3, 5'b00000, 5'b01011, 1'b1);   // dw lets go
      add_row(5'b10100, 1, 5'b00100, 5'b01011, 1'b0);   // dm next
      add_row(5'b10100, 4, 5'b00100, 5'b01011, 1'b0);
      add_row(5'b10000, 2, 5'b00100, 5'b01111, 1'b0);   // dm release in flight
      add_row(5'b10000, 1, 5'b00000, 5'b01111, 1'b1);   // gap
      add_row(5'b10000, 1, 5'b10000, 5'b01111, 1'b0);   // my last
      add_row(5'b10000, 4, 5'b10000, 5'b01111, 1'b0);
   endtask

   //**************************************************
   // main sequence
   //**************************************************

   initial begin
      sdclock     = 1'b0;
      reset_i     = 1'b1;
      disk_req_i  = '0;
      disk_spi_i  = '0;
      spi_pat     = '0;
      lcg_state   = 32'h6026;
      err_count   = 0;
      check_count = 0;
      timed_out   = 1'b0;
      build_table();
      fill_patterns();
      disk_spi_i = spi_pat;

      // reset held for two edges
      for (int i = 0; i < 2; i++) begin
         @(posedge sdclock);
         #1;
         check_outputs('0, 5'b11111, expected_card('0, spi_pat, 1'b1));
      end
      #1;
      reset_i = 1'b0;                  // 2 ns after the edge

      foreach (rows[r]) begin
         fill_patterns();              // fresh lines every row
         disk_req_i = rows[r].req;
         disk_spi_i = spi_pat;
         for (int c = 0; c < rows[r].cycles; c++) begin
            @(posedge sdclock);
         end
         #1;                           // sample before the next drive
         check_outputs(rows[r].gnt, rows[r].led,
                       expected_card(rows[r].gnt, spi_pat, rows[r].idle));
         #1;
      end

      // my still holds and now lets go
      disk_req_i = '0;
      wait_card_free(20);
      if (!timed_out) begin
         check_outputs('0, 5'b11111, expected_card('0, spi_pat, 1'b1));
      end

      $display("checks: %0d  errors: %0d  timeout: %0d", check_count, err_count, timed_out);
      if (err_count == 0 && !timed_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
hdl/sd_share_pkg.sv
hdl/sd_req_filter.sv
hdl/sd_arbiter.sv
hdl/sd_backplane.sv
dv/sd_arbiter_asserts.sv
dv/sd_backplane_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert --top-module sd_backplane_tb -f tb.f \
   -o sd_backplane_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/sd_backplane_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
   && echo "RESULT: PASS" \
   || { echo "RESULT: FAIL"; exit 1; }
